/* common/decode_macros.svh */
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath widths
`define IR_W 128
`define EIP_W 32

// opcodes with special merge rules
`define OP_MOVQ_ST 16'h0F7F
`define OP_CMPXCHG 16'h0FB0

`define REG_ESP 3'd4
`define UCODE_NOP '0

`endif

/* common/decode_pkg.sv */
`default_nettype none

package decode_pkg;

   // width code for displacement, immediate and far offset fields
   typedef enum logic [1:0] {
      SZ8  = 2'b00,
      SZ16 = 2'b01,
      SZ32 = 2'b10,
      SZ48 = 2'b11
   } field_size_t;

   typedef enum logic [1:0] {
      OS8  = 2'b00,
      OS16 = 2'b01,
      OS32 = 2'b10,
      OS64 = 2'b11
   } op_size_t;

   typedef enum logic [2:0] {
      ES = 3'd0,
      CS = 3'd1,
      SS = 3'd2,
      DS = 3'd3,
      FS = 3'd4,
      GS = 3'd5
   } seg_id_t;

   typedef enum logic [2:0] {
      ADD  = 3'd0,
      OR   = 3'd1,
      ADC  = 3'd2,
      SBB  = 3'd3,
      AND  = 3'd4,
      SUB  = 3'd5,
      XOR  = 3'd6,
      PASS = 3'd7
   } aluk_t;

   // each mux_* bit selects the microcode value over the modrm-derived one
   typedef struct packed {
      op_size_t    op_size;
      logic        mux_op_size;
      logic        mem_rd;
      logic        mux_mem_rd;
      logic        mem_wr;
      logic        mux_mem_wr;
      logic        ld_gpr1;
      logic        mux_ld_gpr1;
      aluk_t       aluk;
      logic        mux_aluk;
      logic [2:0]  sr1;
      logic        mux_sr1;
      logic [2:0]  sr2;
      logic        mux_sr2;
      logic        mux_seg2;
      logic        seg1_needed;
      logic        sr1_needed;
      logic        mm1_needed;
      logic        ld_mm;
   } ucode_t;

endpackage

`default_nettype wire

/* control_store/decode_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_control (
   input  decode_pkg::ucode_t      word,
   input  logic [15:0]             opcode,
   input  logic [7:0]              modrm,
   input  logic                    modrm_present,
   input  logic                    operand_override,
   input  decode_pkg::field_size_t offset_size,
   output decode_pkg::op_size_t    sr1_size,
   output decode_pkg::op_size_t    mem_size,
   output decode_pkg::op_size_t    dr1_size,
   output decode_pkg::field_size_t off_size,
   output logic                    mem_rd,
   output logic                    mem_wr,
   output logic                    ld_gpr1,
   output logic                    ld_mm,
   output logic                    sr1_needed,
   output logic                    seg1_needed,
   output logic                    mm1_needed,
   output decode_pkg::aluk_t       aluk,
   output logic                    cmpxchg,
   output logic                    base_reg_en
);
   import decode_pkg::*;

   localparam logic [15:0] OP_JMP_FAR = 16'h00EA;

   logic     mod_mem;
   logic     mod_reg;
   logic     is_movq_st;
   op_size_t op_size;

   assign mod_mem    = modrm_present && (modrm[7:6] != 2'b11);
   assign mod_reg    = (modrm[7:6] == 2'b11);
   assign is_movq_st = (opcode == `OP_MOVQ_ST);

   // the size prefix chooses 16 or 32 bits unless microcode fixes it
   assign op_size = word.mux_op_size ? word.op_size : (operand_override ? OS16 : OS32);

   assign mem_size = op_size;
   assign dr1_size = op_size;
   // memory forms read a 32-bit address register
   assign sr1_size = mod_mem ? OS32 : op_size;

   assign mem_rd  = word.mux_mem_rd ? word.mem_rd : mod_mem;
   assign mem_wr  = word.mux_mem_wr ? word.mem_wr : mod_mem;
   assign ld_gpr1 = word.mux_ld_gpr1 ? word.ld_gpr1 : mod_reg;
   assign aluk    = word.mux_aluk ? word.aluk : aluk_t'(modrm[5:3]);

   assign sr1_needed  = word.sr1_needed || mod_mem;
   assign seg1_needed = word.seg1_needed || mod_mem;

   // movq store with a register destination writes the mmx file
   assign ld_mm      = word.ld_mm || (mod_reg && is_movq_st);
   assign mm1_needed = word.mm1_needed && mod_reg && !is_movq_st;

   // 0FB0 and 0FB1 differ only in bit 0
   assign cmpxchg = ({opcode[15:1], 1'b0} == `OP_CMPXCHG);

   // mod 00 rm 101 is disp32 with no base register
   assign base_reg_en = !((modrm[7:6] == 2'b00) && (modrm[2:0] == 3'b101));

   // far jmp under the size prefix carries a 16:16 pointer
   assign off_size = (operand_override && opcode == OP_JMP_FAR) ? SZ32 : offset_size;

endmodule

`default_nettype wire

/* control_store/ucontrol_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module ucontrol_store (
   input  logic [7:0]        opcode,
   input  logic              opcode_size,
   output decode_pkg::ucode_t word
);
   import decode_pkg::*;

   // opcodes not listed below decode as a no-op word
   always_comb begin
      word = `UCODE_NOP;
      case ({opcode_size, opcode})
         9'h001: begin
            word.aluk       = ADD;
            word.mux_aluk   = 1'b1;
            word.sr1_needed = 1'b1;
         end
         9'h08B: begin
            word.aluk        = PASS;
            word.mux_aluk    = 1'b1;
            word.ld_gpr1     = 1'b1;
            word.mux_ld_gpr1 = 1'b1;
            word.mux_mem_wr  = 1'b1;
         end
         // group 1 takes its alu op from modrm reg
         9'h081: begin
            word.sr1_needed = 1'b1;
         end
         9'h006: begin
            word.mem_wr      = 1'b1;
            word.mux_mem_wr  = 1'b1;
            word.mux_mem_rd  = 1'b1;
            word.sr1         = `REG_ESP;
            word.mux_sr1     = 1'b1;
            word.seg1_needed = 1'b1;
            word.mux_seg2    = 1'b1;
         end
         9'h17F: begin
            word.op_size     = OS64;
            word.mux_op_size = 1'b1;
            word.mm1_needed  = 1'b1;
         end
         // cmpxchg compares against eax
         9'h1B0, 9'h1B1: begin
            word.aluk     = SUB;
            word.mux_aluk = 1'b1;
            word.sr2      = 3'd0;
            word.mux_sr2  = 1'b1;
         end
         default: begin
            word = `UCODE_NOP;
         end
      endcase
   end

endmodule

`default_nettype wire

/* dv/decode_stage2_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage2_tb;
   import decode_pkg::*;

   // about 80 cycles of tests, plus slack
   localparam int TEST_CYCLES   = 80;
   localparam int MARGIN_CYCLES = 40;

   logic clk, reset, valid_in, stall;
   logic [`IR_W-1:0] ir;
   logic [`EIP_W-1:0] eip;
   logic [15:0] cs;
   logic [3:0] instr_length;
   logic [15:0] opcode;
   logic opcode_size, operand_override, segment_override;
   seg_id_t seg_id;
   logic modrm_present, sib_present, disp_present;
   logic [7:0] modrm, sib;
   logic [3:0] disp_sel, imm_sel, off_sel;
   field_size_t disp_size, imm_size, offset_size;

   logic valid_out;
   logic [`EIP_W-1:0] eip_out;
   logic [15:0] cs_out;
   logic [31:0] disp32, imm32;
   logic [47:0] offset48;
   logic disp_en, mux_seg;
   logic [2:0] sr1, sr2, sr3, sr4;
   seg_id_t seg1, seg2;
   op_size_t sr1_size, mem_size, dr1_size;
   logic mem_rd, mem_wr, ld_gpr1, ld_mm, sr1_needed, seg1_needed, mm1_needed;
   aluk_t aluk;
   logic cmpxchg, base_reg_en;

   // expected values of the instruction in flight
   logic exp_valid, exp_disp_en, exp_mux_seg, exp_base_reg_en, exp_cmpxchg;
   logic [31:0] exp_eip, exp_disp, exp_imm;
   logic [47:0] exp_off;
   logic [15:0] exp_cs;
   logic [2:0] exp_sr1, exp_sr2, exp_sr3, exp_sr4, exp_seg1, exp_seg2, exp_aluk;
   logic [1:0] exp_sr1_size, exp_mem_size, exp_dr1_size;
   logic exp_mem_rd, exp_mem_wr, exp_ld_gpr1, exp_ld_mm;
   logic exp_sr1_needed, exp_seg1_needed, exp_mm1_needed;

   integer seed;
   integer errors;
   integer checks;

   decode_stage2 decode_stage2_i (.*);

   always #20 clk = ~clk;

   initial begin
      #((TEST_CYCLES + MARGIN_CYCLES) * 40);
      $display("timeout: the tests did not finish in time, errors so far %0d", errors);
      $display("CHECKS FAILED");
      $finish;
   end

   function automatic logic [31:0] next_random();
      return $random(seed);
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
         input logic [63:0] exp);
      checks = checks + 1;
      assert (got === exp) else begin
         errors = errors + 1;
         $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   // little-endian bytes from sel on, then sign or zero extension
   function automatic logic [47:0] field_value(input logic [127:0] bits,
         input logic [3:0] sel, input field_size_t size, input int width);
      logic [47:0] v;
      v = '0;
      for (int i = 0; i < 6; i++) begin
         if (sel + i < 16) begin
            v[8*i +: 8] = bits[8*(sel+i) +: 8];
         end
      end
      case (size)
         SZ8:     v = {{40{v[7]}}, v[7:0]};
         SZ16:    v = {{32{v[15]}}, v[15:0]};
         SZ32:    v = {16'h0000, v[31:0]};
         default: v = v;
      endcase
      if (width == 32) begin
         v = {16'h0000, v[31:0]};
      end
      return v;
   endfunction

   function automatic logic [2:0] seg1_model();
      logic stack;
      stack = (sib_present && sib[2:0] == 3'b100) ||
              (modrm_present && (modrm[7:6] == 2'b01 || modrm[7:6] == 2'b10) &&
               modrm[2:0] == 3'b101);
      if (segment_override) begin
         return seg_id;
      end
      case ({opcode_size, opcode[7:0]})
         9'h006, 9'h007: return ES;
         9'h00E:         return CS;
         9'h016, 9'h017: return SS;
         9'h01E, 9'h01F: return DS;
         9'h1A0, 9'h1A1: return FS;
         9'h1A8, 9'h1A9: return GS;
         default: ;
      endcase
      if (stack) begin
         return SS;
      end
      return DS;
   endfunction

   task automatic predict();
      logic mod_mem, mod_reg, movq;
      logic mx_os, mx_rd, mx_wr, mx_ld, mx_alu, mx_sr1, mx_sr2, mx_seg2;
      logic u_wr, u_ld, u_sr1n, u_seg1n, u_mm1n;
      logic [2:0] u_alu;
      logic [1:0] os;
      logic [2:0] base;
      {mx_os, mx_rd, mx_wr, mx_ld, mx_alu, mx_sr1, mx_sr2, mx_seg2} = '0;
      {u_wr, u_ld, u_sr1n, u_seg1n, u_mm1n} = '0;
      u_alu = 3'd0;
      // microcode table
      case ({opcode_size, opcode[7:0]})
         9'h001: begin
            mx_alu = 1'b1;
            u_alu = ADD;
            u_sr1n = 1'b1;
         end
         9'h08B: begin
            mx_alu = 1'b1;
            u_alu = PASS;
            mx_ld = 1'b1;
            u_ld = 1'b1;
            mx_wr = 1'b1;
         end
         9'h081: u_sr1n = 1'b1;
         9'h006: begin
            mx_wr = 1'b1;
            u_wr = 1'b1;
            mx_rd = 1'b1;
            mx_sr1 = 1'b1;
            u_seg1n = 1'b1;
            mx_seg2 = 1'b1;
         end
         9'h17F: begin
            mx_os = 1'b1;
            u_mm1n = 1'b1;
         end
         9'h1B0, 9'h1B1: begin
            mx_alu = 1'b1;
            u_alu = SUB;
            mx_sr2 = 1'b1;
         end
         default: ;
      endcase
      mod_mem = modrm_present && (modrm[7:6] != 2'b11);
      mod_reg = (modrm[7:6] == 2'b11);
      movq = (opcode == `OP_MOVQ_ST);
      os = mx_os ? OS64 : (operand_override ? OS16 : OS32);
      exp_mem_size = os;
      exp_dr1_size = os;
      exp_sr1_size = mod_mem ? OS32 : os;
      exp_mem_rd = mx_rd ? 1'b0 : mod_mem;
      exp_mem_wr = mx_wr ? u_wr : mod_mem;
      exp_ld_gpr1 = mx_ld ? u_ld : mod_reg;
      exp_aluk = mx_alu ? u_alu : modrm[5:3];
      exp_sr1_needed = u_sr1n || mod_mem;
      exp_seg1_needed = u_seg1n || mod_mem;
      exp_ld_mm = mod_reg && movq;
      exp_mm1_needed = u_mm1n && mod_reg && !movq;
      exp_cmpxchg = (opcode == 16'h0FB0) || (opcode == 16'h0FB1);
      exp_base_reg_en = !(modrm[7:6] == 2'b00 && modrm[2:0] == 3'b101);
      base = sib_present ? sib[2:0] : modrm[2:0];
      exp_sr1 = mx_sr1 ? `REG_ESP : base;
      exp_sr2 = mx_sr2 ? 3'd0 : modrm[5:3];
      exp_sr3 = modrm[5:3];
      exp_sr4 = sib[5:3];
      exp_seg1 = seg1_model();
      exp_seg2 = mx_seg2 ? modrm[5:3] : SS;
      exp_mux_seg = (seg_id == CS);
      exp_disp = field_value(ir, disp_sel, disp_size, 32);
      exp_imm = field_value(ir, imm_sel, imm_size, 32);
      exp_off = field_value(ir, off_sel,
                            (operand_override && opcode == 16'h00EA) ? SZ32 : offset_size, 48);
      exp_eip = eip + instr_length;
      exp_cs = cs;
      exp_disp_en = disp_present;
      exp_valid = valid_in;
   endtask

   task automatic check_all();
      check_value("valid_out", valid_out, exp_valid);
      // payload is only defined for a valid instruction
      if (exp_valid) begin
         check_value("eip_out", eip_out, exp_eip);
         check_value("cs_out", cs_out, exp_cs);
         check_value("disp32", disp32, exp_disp);
         check_value("imm32", imm32, exp_imm);
         check_value("offset48", offset48, exp_off);
         check_value("disp_en", disp_en, exp_disp_en);
         check_value("sr1", sr1, exp_sr1);
         check_value("sr2", sr2, exp_sr2);
         check_value("sr3", sr3, exp_sr3);
         check_value("sr4", sr4, exp_sr4);
         check_value("seg1", seg1, exp_seg1);
         check_value("seg2", seg2, exp_seg2);
         check_value("mux_seg", mux_seg, exp_mux_seg);
         check_value("sr1_size", sr1_size, exp_sr1_size);
         check_value("mem_size", mem_size, exp_mem_size);
         check_value("dr1_size", dr1_size, exp_dr1_size);
         check_value("mem_rd", mem_rd, exp_mem_rd);
         check_value("mem_wr", mem_wr, exp_mem_wr);
         check_value("ld_gpr1", ld_gpr1, exp_ld_gpr1);
         check_value("ld_mm", ld_mm, exp_ld_mm);
         check_value("sr1_needed", sr1_needed, exp_sr1_needed);
         check_value("seg1_needed", seg1_needed, exp_seg1_needed);
         check_value("mm1_needed", mm1_needed, exp_mm1_needed);
         check_value("aluk", aluk, exp_aluk);
         check_value("cmpxchg", cmpxchg, exp_cmpxchg);
         check_value("base_reg_en", base_reg_en, exp_base_reg_en);
      end
   endtask

   task automatic run_instr();
      predict();
      next_cycle();
      check_all();
   endtask

   task automatic clear_inputs();
      {valid_in, stall, ir, eip, cs, instr_length, opcode, opcode_size} = '0;
      {operand_override, segment_override, modrm_present, modrm} = '0;
      {sib_present, sib, disp_present, disp_sel, imm_sel, off_sel} = '0;
      seg_id = ES;
      disp_size = SZ8;
      imm_size = SZ8;
      offset_size = SZ8;
   endtask

   task automatic randomize_instr();
      valid_in = 1'b1;
      stall = 1'b0;
      ir = {next_random(), next_random(), next_random(), next_random()};
      eip = next_random();
      cs = 16'(next_random());
      instr_length = 4'(next_random());
      opcode_size = 1'(next_random());
      opcode = {opcode_size ? 8'h0F : 8'h00, 8'(next_random())};
      operand_override = 1'(next_random());
      segment_override = 1'(next_random());
      seg_id = seg_id_t'(3'(next_random() % 6));
      modrm_present = 1'(next_random());
      modrm = 8'(next_random());
      sib_present = 1'(next_random());
      sib = 8'(next_random());
      disp_present = 1'(next_random());
      disp_sel = 4'(next_random());
      disp_size = field_size_t'(2'(next_random()));
      imm_sel = 4'(next_random());
      imm_size = field_size_t'(2'(next_random()));
      off_sel = 4'(next_random());
      offset_size = field_size_t'(2'(next_random()));
   endtask

   task automatic set_decode(input logic [15:0] op, input logic [7:0] m, input logic sp,
         input logic [7:0] s);
      opcode = op;
      opcode_size = (op[15:8] == 8'h0F);
      modrm_present = 1'b1;
      modrm = m;
      sib_present = sp;
      sib = s;
   endtask

   task automatic test_reset_hold();
      reset = 1'b1;
      // a valid memory form mov raises the controls unless reset holds them low
      valid_in = 1'b1;
      set_decode(16'h008B, 8'h00, 1'b0, 8'h00);
      repeat (4) next_cycle();
      check_value("valid_out", valid_out, 1'b0);
      check_value("controls", {mem_rd, mem_wr, ld_gpr1, ld_mm, sr1_needed, seg1_needed,
                               mm1_needed, cmpxchg}, 8'h00);
      reset = 1'b0;
      randomize_instr();
      run_instr();
      // new inputs under stall must not reach the outputs
      randomize_instr();
      stall = 1'b1;
      repeat (3) begin
         next_cycle();
         check_all();
      end
      stall = 1'b0;
      run_instr();
   endtask

   task automatic test_fields();
      for (int i = 0; i < 12; i++) begin
         randomize_instr();
         run_instr();
      end
      // far jmp with the size prefix takes a 32-bit offset
      randomize_instr();
      opcode = 16'h00EA;
      opcode_size = 1'b0;
      operand_override = 1'b1;
      offset_size = SZ48;
      off_sel = 4'd1;
      run_instr();
      check_value("offset48", offset48, {16'h0000, ir[39:8]});
   endtask

   task automatic test_ucode_merge();
      logic [15:0] ops [0:3];
      ops[0] = 16'h0001;
      ops[1] = 16'h008B;
      ops[2] = 16'h0081;
      ops[3] = `OP_MOVQ_ST;
      for (int i = 0; i < 4; i++) begin
         for (int f = 0; f < 4; f++) begin
            for (int ov = 0; ov < 2; ov++) begin
               randomize_instr();
               set_decode(ops[i], {2'(f), 6'(next_random())}, 1'b0, 8'h00);
               operand_override = ov[0];
               run_instr();
            end
         end
      end
   endtask

   task automatic run_seg_case(input logic [15:0] op, input logic [7:0] m, input logic sp,
         input logic [7:0] s, input logic ovr, input seg_id_t id, input seg_id_t want);
      randomize_instr();
      set_decode(op, m, sp, s);
      segment_override = ovr;
      seg_id = id;
      run_instr();
      check_value("seg1", seg1, want);
      check_value("mux_seg", mux_seg, id == CS);
   endtask

   task automatic test_segments();
      run_seg_case(16'h0006, 8'h44, 1'b1, 8'h24, 1'b1, FS, FS);
      run_seg_case(16'h0FA8, 8'h45, 1'b1, 8'h24, 1'b0, ES, GS);
      run_seg_case(16'h0017, 8'h85, 1'b0, 8'h00, 1'b0, ES, SS);
      run_seg_case(16'h000E, 8'hC0, 1'b0, 8'h00, 1'b0, CS, CS);
      run_seg_case(16'h008B, 8'h85, 1'b0, 8'h00, 1'b0, DS, SS);
      run_seg_case(16'h008B, 8'h04, 1'b1, 8'h24, 1'b0, DS, SS);
      run_seg_case(16'h008B, 8'h05, 1'b0, 8'h00, 1'b1, CS, CS);
      run_seg_case(16'h008B, 8'h05, 1'b0, 8'h00, 1'b0, GS, DS);
   endtask

   task automatic test_reg_ids();
      logic [15:0] op;
      for (int i = 0; i < 4; i++) begin
         randomize_instr();
         sib_present = i[0];
         run_instr();
      end
      // push es addresses the stack through esp
      randomize_instr();
      set_decode(16'h0006, 8'(next_random()), 1'b1, 8'(next_random()));
      run_instr();
      check_value("sr1", sr1, `REG_ESP);
      randomize_instr();
      set_decode(16'h0001, 8'h05, 1'b0, 8'h00);
      run_instr();
      check_value("base_reg_en", base_reg_en, 1'b0);
      randomize_instr();
      set_decode(16'h0001, 8'h45, 1'b0, 8'h00);
      run_instr();
      check_value("base_reg_en", base_reg_en, 1'b1);
      for (int i = 0; i < 3; i++) begin
         op = `OP_CMPXCHG + 16'(i);
         randomize_instr();
         set_decode(op, 8'(next_random()), 1'b0, 8'h00);
         run_instr();
         check_value("cmpxchg", cmpxchg, i < 2);
      end
   endtask

   task automatic test_throughput();
      for (int i = 0; i < 6; i++) begin
         randomize_instr();
         run_instr();
      end
      randomize_instr();
      valid_in = 1'b0;
      run_instr();
      randomize_instr();
      run_instr();
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      errors = 0;
      checks = 0;
      seed = 32'h7746_4fe5;
      clear_inputs();
      test_reset_hold();
      test_fields();
      test_ucode_merge();
      test_segments();
      test_reg_ids();
      test_throughput();
      $display("errors: %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/d2_pipe_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module d2_pipe_reg (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    valid_in,
   input  logic                    stall,
   input  logic [`EIP_W-1:0]       eip,
   input  logic [15:0]             cs,
   input  logic [3:0]              instr_length,
   input  logic [31:0]             disp32_d,
   input  logic [31:0]             imm32_d,
   input  logic [47:0]             offset48_d,
   input  logic                    disp_en_d,
   input  logic [2:0]              sr1_d, sr2_d, sr3_d, sr4_d,
   input  decode_pkg::seg_id_t     seg1_d, seg2_d,
   input  logic                    mux_seg_d,
   input  decode_pkg::op_size_t    sr1_size_d, mem_size_d, dr1_size_d,
   input  logic                    mem_rd_d, mem_wr_d, ld_gpr1_d, ld_mm_d,
   input  logic                    sr1_needed_d, seg1_needed_d, mm1_needed_d,
   input  decode_pkg::aluk_t       aluk_d,
   input  logic                    cmpxchg_d,
   input  logic                    base_reg_en_d,
   output logic                    valid_out,
   output logic [`EIP_W-1:0]       eip_out,
   output logic [15:0]             cs_out,
   output logic [31:0]             disp32,
   output logic [31:0]             imm32,
   output logic [47:0]             offset48,
   output logic                    disp_en,
   output logic [2:0]              sr1, sr2, sr3, sr4,
   output decode_pkg::seg_id_t     seg1, seg2,
   output logic                    mux_seg,
   output decode_pkg::op_size_t    sr1_size, mem_size, dr1_size,
   output logic                    mem_rd, mem_wr, ld_gpr1, ld_mm,
   output logic                    sr1_needed, seg1_needed, mm1_needed,
   output decode_pkg::aluk_t       aluk,
   output logic                    cmpxchg,
   output logic                    base_reg_en
);
   import decode_pkg::*;

   // control bits, cleared so nothing fires downstream after reset
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_out   <= 1'b0;
         mem_rd      <= 1'b0;
         mem_wr      <= 1'b0;
         ld_gpr1     <= 1'b0;
         ld_mm       <= 1'b0;
         sr1_needed  <= 1'b0;
         seg1_needed <= 1'b0;
         mm1_needed  <= 1'b0;
         cmpxchg     <= 1'b0;
      end else if (!stall) begin
         valid_out   <= valid_in;
         mem_rd      <= mem_rd_d;
         mem_wr      <= mem_wr_d;
         ld_gpr1     <= ld_gpr1_d;
         ld_mm       <= ld_mm_d;
         sr1_needed  <= sr1_needed_d;
         seg1_needed <= seg1_needed_d;
         mm1_needed  <= mm1_needed_d;
         cmpxchg     <= cmpxchg_d;
      end
   end

   // payload only matters while valid_out is high
   always_ff @(posedge clk) begin
      if (!stall) begin
         eip_out     <= eip + {{(`EIP_W-4){1'b0}}, instr_length};
         cs_out      <= cs;
         disp32      <= disp32_d;
         imm32       <= imm32_d;
         offset48    <= offset48_d;
         disp_en     <= disp_en_d;
         sr1         <= sr1_d;
         sr2         <= sr2_d;
         sr3         <= sr3_d;
         sr4         <= sr4_d;
         seg1        <= seg1_d;
         seg2        <= seg2_d;
         mux_seg     <= mux_seg_d;
         sr1_size    <= sr1_size_d;
         mem_size    <= mem_size_d;
         dr1_size    <= dr1_size_d;
         aluk        <= aluk_d;
         base_reg_en <= base_reg_en_d;
      end
   end

endmodule

`default_nettype wire

/* rtl/decode_stage2.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage2 (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    valid_in,
   input  logic                    stall,
   input  logic [`IR_W-1:0]        ir,
   input  logic [`EIP_W-1:0]       eip,
   input  logic [15:0]             cs,
   input  logic [3:0]              instr_length,
   input  logic [15:0]             opcode,
   input  logic                    opcode_size,
   input  logic                    operand_override,
   input  logic                    segment_override,
   input  decode_pkg::seg_id_t     seg_id,
   input  logic                    modrm_present,
   input  logic [7:0]              modrm,
   input  logic                    sib_present,
   input  logic [7:0]              sib,
   input  logic                    disp_present,
   input  logic [3:0]              disp_sel,
   input  decode_pkg::field_size_t disp_size,
   input  logic [3:0]              imm_sel,
   input  decode_pkg::field_size_t imm_size,
   input  logic [3:0]              off_sel,
   input  decode_pkg::field_size_t offset_size,
   output logic                    valid_out,
   output logic [`EIP_W-1:0]       eip_out,
   output logic [15:0]             cs_out,
   output logic [31:0]             disp32,
   output logic [31:0]             imm32,
   output logic [47:0]             offset48,
   output logic                    disp_en,
   output logic [2:0]              sr1, sr2, sr3, sr4,
   output decode_pkg::seg_id_t     seg1, seg2,
   output logic                    mux_seg,
   output decode_pkg::op_size_t    sr1_size, mem_size, dr1_size,
   output logic                    mem_rd, mem_wr, ld_gpr1, ld_mm,
   output logic                    sr1_needed, seg1_needed, mm1_needed,
   output decode_pkg::aluk_t       aluk,
   output logic                    cmpxchg,
   output logic                    base_reg_en
);
   import decode_pkg::*;

   ucode_t      uword;
   field_size_t off_size;
   logic [31:0] disp32_d;
   logic [31:0] imm32_d;
   logic [47:0] offset48_d;
   logic [2:0]  sr1_d, sr2_d, sr3_d, sr4_d;
   seg_id_t     seg1_d, seg2_d;
   logic        mux_seg_d;
   op_size_t    sr1_size_d, mem_size_d, dr1_size_d;
   logic        mem_rd_d, mem_wr_d, ld_gpr1_d, ld_mm_d;
   logic        sr1_needed_d, seg1_needed_d, mm1_needed_d;
   aluk_t       aluk_d;
   logic        cmpxchg_d;
   logic        base_reg_en_d;

   ucontrol_store u_ucontrol_store (
      .opcode(opcode[7:0]), .opcode_size(opcode_size), .word(uword)
   );

   decode_control u_decode_control (
      .word(uword), .opcode(opcode), .modrm(modrm), .modrm_present(modrm_present),
      .operand_override(operand_override), .offset_size(offset_size),
      .sr1_size(sr1_size_d), .mem_size(mem_size_d), .dr1_size(dr1_size_d),
      .off_size(off_size), .mem_rd(mem_rd_d), .mem_wr(mem_wr_d), .ld_gpr1(ld_gpr1_d),
      .ld_mm(ld_mm_d), .sr1_needed(sr1_needed_d), .seg1_needed(seg1_needed_d),
      .mm1_needed(mm1_needed_d), .aluk(aluk_d), .cmpxchg(cmpxchg_d),
      .base_reg_en(base_reg_en_d)
   );

   field_selector #(.field_t(logic [31:0])) u_disp_sel (
      .ir(ir), .sel(disp_sel), .size(disp_size), .field(disp32_d)
   );

   field_selector #(.field_t(logic [31:0])) u_imm_sel (
      .ir(ir), .sel(imm_sel), .size(imm_size), .field(imm32_d)
   );

   field_selector #(.field_t(logic [47:0])) u_off_sel (
      .ir(ir), .sel(off_sel), .size(off_size), .field(offset48_d)
   );

   segment_select u_segment_select (
      .opcode(opcode[7:0]), .opcode_size(opcode_size),
      .segment_override(segment_override), .seg_id(seg_id), .modrm(modrm),
      .modrm_present(modrm_present), .sib(sib), .sib_present(sib_present), .word(uword),
      .seg1(seg1_d), .seg2(seg2_d), .mux_seg(mux_seg_d)
   );

   reg_id_select u_reg_id_select (
      .modrm(modrm), .sib(sib), .sib_present(sib_present), .word(uword),
      .sr1(sr1_d), .sr2(sr2_d), .sr3(sr3_d), .sr4(sr4_d)
   );

   d2_pipe_reg u_d2_pipe_reg (
      .clk(clk), .reset(reset), .valid_in(valid_in), .stall(stall),
      .eip(eip), .cs(cs), .instr_length(instr_length),
      .disp32_d(disp32_d), .imm32_d(imm32_d), .offset48_d(offset48_d),
      .disp_en_d(disp_present),
      .sr1_d(sr1_d), .sr2_d(sr2_d), .sr3_d(sr3_d), .sr4_d(sr4_d),
      .seg1_d(seg1_d), .seg2_d(seg2_d), .mux_seg_d(mux_seg_d),
      .sr1_size_d(sr1_size_d), .mem_size_d(mem_size_d), .dr1_size_d(dr1_size_d),
      .mem_rd_d(mem_rd_d), .mem_wr_d(mem_wr_d), .ld_gpr1_d(ld_gpr1_d), .ld_mm_d(ld_mm_d),
      .sr1_needed_d(sr1_needed_d), .seg1_needed_d(seg1_needed_d),
      .mm1_needed_d(mm1_needed_d), .aluk_d(aluk_d), .cmpxchg_d(cmpxchg_d),
      .base_reg_en_d(base_reg_en_d),
      .valid_out(valid_out), .eip_out(eip_out), .cs_out(cs_out),
      .disp32(disp32), .imm32(imm32), .offset48(offset48), .disp_en(disp_en),
      .sr1(sr1), .sr2(sr2), .sr3(sr3), .sr4(sr4),
      .seg1(seg1), .seg2(seg2), .mux_seg(mux_seg),
      .sr1_size(sr1_size), .mem_size(mem_size), .dr1_size(dr1_size),
      .mem_rd(mem_rd), .mem_wr(mem_wr), .ld_gpr1(ld_gpr1), .ld_mm(ld_mm),
      .sr1_needed(sr1_needed), .seg1_needed(seg1_needed), .mm1_needed(mm1_needed),
      .aluk(aluk), .cmpxchg(cmpxchg), .base_reg_en(base_reg_en)
   );

endmodule

`default_nettype wire

/* rtl/field_selector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module field_selector #(
   parameter type field_t = logic [31:0]
) (
   input  logic [`IR_W-1:0]        ir,
   input  logic [3:0]              sel,
   input  decode_pkg::field_size_t size,
   output field_t                  field
);
   import decode_pkg::*;

   localparam int FW = $bits(field_t);

   logic [47:0]   raw;
   logic [FW-1:0] ext;

   // byte sel of ir lands in raw[7:0], little-endian
   assign raw = 48'(ir >> {sel, 3'b000});

   always_comb begin
      case (size)
         SZ8:     ext = FW'($signed(raw[7:0]));
         SZ16:    ext = FW'($signed(raw[15:0]));
         SZ32:    ext = FW'(raw[31:0]);
         default: ext = FW'(raw);
      endcase
   end

   assign field = ext;

endmodule

`default_nettype wire

/* rtl/reg_id_select.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_id_select (
   input  logic [7:0]         modrm,
   input  logic [7:0]         sib,
   input  logic               sib_present,
   input  decode_pkg::ucode_t word,
   output logic [2:0]         sr1,
   output logic [2:0]         sr2,
   output logic [2:0]         sr3,
   output logic [2:0]         sr4
);
   import decode_pkg::*;

   logic [2:0] base_reg;

   // sib base replaces rm when a sib byte follows
   assign base_reg = sib_present ? sib[2:0] : modrm[2:0];

   assign sr1 = word.mux_sr1 ? word.sr1 : base_reg;
   assign sr2 = word.mux_sr2 ? word.sr2 : modrm[5:3];
   assign sr3 = modrm[5:3];
   // index register for the address stage
   assign sr4 = sib[5:3];

endmodule

`default_nettype wire

/* rtl/segment_select.sv */
`timescale 1ns/1ps
`default_nettype none

module segment_select (
   input  logic [7:0]          opcode,
   input  logic                opcode_size,
   input  logic                segment_override,
   input  decode_pkg::seg_id_t seg_id,
   input  logic [7:0]          modrm,
   input  logic                modrm_present,
   input  logic [7:0]          sib,
   input  logic                sib_present,
   input  decode_pkg::ucode_t  word,
   output decode_pkg::seg_id_t seg1,
   output decode_pkg::seg_id_t seg2,
   output logic                mux_seg
);
   import decode_pkg::*;

   logic    pp_hit;
   seg_id_t pp_seg;
   logic    stack_addr;

   // push and pop of a segment register name it in the opcode
   always_comb begin
      pp_hit = 1'b1;
      pp_seg = DS;
      if (!opcode_size) begin
         case (opcode)
            8'h06, 8'h07: pp_seg = ES;
            8'h0E:        pp_seg = CS;
            8'h16, 8'h17: pp_seg = SS;
            8'h1E, 8'h1F: pp_seg = DS;
            default:      pp_hit = 1'b0;
         endcase
      end else begin
         case (opcode)
            8'hA0, 8'hA1: pp_seg = FS;
            8'hA8, 8'hA9: pp_seg = GS;
            default:      pp_hit = 1'b0;
         endcase
      end
   end

   // esp base in sib, or ebp base with a displacement
   assign stack_addr = (sib_present && sib[2:0] == 3'b100) ||
                       (modrm_present && (modrm[7:6] == 2'b01 || modrm[7:6] == 2'b10) &&
                        modrm[2:0] == 3'b101);

   always_comb begin
      if (segment_override) begin
         seg1 = seg_id;
      end else if (pp_hit) begin
         seg1 = pp_seg;
      end else if (stack_addr) begin
         seg1 = SS;
      end else begin
         seg1 = DS;
      end
   end

   assign seg2    = word.mux_seg2 ? seg_id_t'(modrm[5:3]) : SS;
   assign mux_seg = (seg_id == CS);

endmodule

`default_nettype wire

/* vlog.f */
+incdir+common
common/decode_pkg.sv
control_store/ucontrol_store.sv
control_store/decode_control.sv
rtl/field_selector.sv
rtl/segment_select.sv
rtl/reg_id_select.sv
rtl/d2_pipe_reg.sv
rtl/decode_stage2.sv
dv/decode_stage2_tb.sv
